// File: Bender.yml
package:
  name: ghash_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/gf_pkg.sv
      - source/clmul_half.sv
      - source/polinomial_mult_koa.sv
      - source/gf_reduce.sv
      - source/ghash_input.sv
      - source/ghash_output.sv
      - source/ghash_core.sv
  - target: test
    files:
      - tb/tb_ghash_core.sv

// File: source/clmul_half.sv
`include "gf_cfg.svh"

module clmul_half
#(
    parameter int NB_DATA = `GF_NB_DATA / 2
)
(
    input  logic [NB_DATA-1:0]   i_data_x,
    input  logic [NB_DATA-1:0]   i_data_y,
    output logic [2*NB_DATA-2:0] o_data_z
);

    localparam int NB_PROD = 2*NB_DATA - 1;

    logic [NB_PROD-1:0] x_ext;

    // x widened to the product width before shifting.
    assign x_ext = {{(NB_DATA-1){1'b0}}, i_data_x};

    // One shifted row of x for every set bit of y.
    always_comb
    begin
        o_data_z = '0;
        for (int i = 0; i < NB_DATA; i++)
        begin
            if (i_data_y[i])
            begin
                o_data_z = o_data_z ^ (x_ext << i);
            end
        end
    end

endmodule

// File: source/gf_cfg.svh
`ifndef GF_CFG_SVH
`define GF_CFG_SVH

// Field width in bits, one GHASH block.
`define GF_NB_DATA 128

// Low terms of the field polynomial, x^7 + x^2 + x + 1.
// Reflected order, so x^0 sits in the MSB.
`define GF_R_POLY 128'hE100_0000_0000_0000_0000_0000_0000_0000

`endif

// File: source/gf_pkg.sv
`include "gf_cfg.svh"

package gf_pkg;

    // Field element, bit 127 holds the x^0 coefficient.
    typedef logic [`GF_NB_DATA-1:0] gf_elem_t;

    // Unreduced product, bit 254 holds the x^0 coefficient.
    typedef logic [2*`GF_NB_DATA-2:0] gf_prod_t;

    // Operand pair handed to the multiplier.
    typedef struct packed {
        gf_elem_t x;
        gf_elem_t h;
        logic     valid;
    } mul_req_t;

    // Input side FSM.
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_WAIT = 1'b1
    } in_state_e;

endpackage

// File: source/gf_reduce.sv
`include "gf_cfg.svh"

module gf_reduce
(
    input  gf_pkg::gf_prod_t i_prod,
    output gf_pkg::gf_elem_t o_elem
);

    localparam int NB_DATA = `GF_NB_DATA;
    localparam int NB_PROD = 2*NB_DATA - 1;

    // Reduction terms lined up with x^0 at the product MSB.
    localparam logic [NB_PROD-1:0] POLY_ALIGNED = {`GF_R_POLY, {(NB_DATA-1){1'b0}}};

    logic [NB_PROD-1:0] fold;

    // Bit j carries degree 254-j, so ascending j folds the highest degree first.
    // Each fold lands at degree k-128 up to k-121, always below the bit being cleared.
    always_comb
    begin
        fold = i_prod;
        for (int j = 0; j < NB_DATA-1; j++)
        begin
            if (fold[j])
            begin
                fold[j] = 1'b0;
                fold = fold ^ (POLY_ALIGNED >> (NB_DATA-2-j));
            end
        end
    end

    // Degrees 0 to 127 remain, still reflected.
    assign o_elem = fold[NB_PROD-1 -: NB_DATA];

endmodule

// File: source/ghash_core.sv
module ghash_core
(
    input  logic             i_clock,
    input  logic             i_rst,
    input  logic             i_key_load,
    input  gf_pkg::gf_elem_t i_key,
    input  logic             i_block_valid,
    input  gf_pkg::gf_elem_t i_block,
    input  logic             i_clear,
    output gf_pkg::gf_elem_t o_tag,
    output logic             o_tag_valid,
    output logic             o_ready
);

    gf_pkg::mul_req_t req;
    gf_pkg::gf_prod_t prod;
    gf_pkg::gf_elem_t reduced;
    gf_pkg::gf_elem_t acc;

    ghash_input u_input
    (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_key_load    (i_key_load),
        .i_key         (i_key),
        .i_block_valid (i_block_valid),
        .i_block       (i_block),
        .i_acc         (acc),
        .o_req         (req),
        .o_ready       (o_ready)
    );

    // Multiply and reduce settle within the cycle after the request.
    polinomial_mult_koa u_mult
    (
        .i_clock  (i_clock),
        .i_data_a (req.x),
        .i_data_b (req.h),
        .o_data   (prod)
    );

    gf_reduce u_reduce
    (
        .i_prod (prod),
        .o_elem (reduced)
    );

    ghash_output u_output
    (
        .i_clock        (i_clock),
        .i_rst          (i_rst),
        .i_clear        (i_clear),
        .i_result       (reduced),
        .i_result_valid (req.valid),
        .o_acc          (acc),
        .o_tag_valid    (o_tag_valid)
    );

    assign o_tag = acc;

endmodule

// File: source/ghash_input.sv
module ghash_input
(
    input  logic              i_clock,
    input  logic              i_rst,
    input  logic              i_key_load,
    input  gf_pkg::gf_elem_t  i_key,
    input  logic              i_block_valid,
    input  gf_pkg::gf_elem_t  i_block,
    input  gf_pkg::gf_elem_t  i_acc,
    output gf_pkg::mul_req_t  o_req,
    output logic              o_ready
);

    gf_pkg::in_state_e state;
    gf_pkg::gf_elem_t  key;
    gf_pkg::gf_elem_t  key_next;
    gf_pkg::gf_elem_t  req_x;
    gf_pkg::gf_elem_t  req_h;
    logic              req_valid;
    logic              accept;

    // A key loaded this cycle already applies to a block taken this cycle.
    assign key_next = i_key_load ? i_key : key;
    assign o_ready  = (state == gf_pkg::ST_IDLE);
    assign accept   = i_block_valid && o_ready;

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            state     <= gf_pkg::ST_IDLE;
            key       <= '0;
            req_valid <= 1'b0;
        end
        else
        begin
            key       <= key_next;
            req_valid <= accept;
            case (state)
                gf_pkg::ST_IDLE:
                begin
                    if (accept)
                    begin
                        state <= gf_pkg::ST_WAIT;
                    end
                end
                gf_pkg::ST_WAIT:
                begin
                    state <= gf_pkg::ST_IDLE;
                end
                default:
                begin
                    state <= gf_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Operand pair, loaded only on an accepted block.
    always_ff @(posedge i_clock)
    begin
        if (accept)
        begin
            req_x <= i_acc ^ i_block;
            req_h <= key_next;
        end
    end

    assign o_req = '{x: req_x, h: req_h, valid: req_valid};

    // The accumulator must settle before the next operand is formed.
    a_req_spaced : assert property (@(posedge i_clock) disable iff (i_rst)
        req_valid |=> !req_valid)
        else $error("ghash_input: back to back multiply requests");

endmodule

// File: source/ghash_output.sv
module ghash_output
(
    input  logic             i_clock,
    input  logic             i_rst,
    input  logic             i_clear,
    input  gf_pkg::gf_elem_t i_result,
    input  logic             i_result_valid,
    output gf_pkg::gf_elem_t o_acc,
    output logic             o_tag_valid
);

    gf_pkg::gf_elem_t acc;
    logic             tag_valid;

    // Clear wins over a result landing in the same cycle.
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            acc       <= '0;
            tag_valid <= 1'b0;
        end
        else if (i_clear)
        begin
            acc       <= '0;
            tag_valid <= 1'b0;
        end
        else if (i_result_valid)
        begin
            acc       <= i_result;
            tag_valid <= 1'b1;
        end
        else
        begin
            tag_valid <= 1'b0;
        end
    end

    assign o_acc       = acc;
    assign o_tag_valid = tag_valid;

    // Input side spacing keeps tag pulses apart.
    a_tag_pulse : assert property (@(posedge i_clock) disable iff (i_rst)
        tag_valid |=> !tag_valid)
        else $error("ghash_output: tag valid held for more than one cycle");

endmodule

// File: source/polinomial_mult_koa.sv
`include "gf_cfg.svh"

module polinomial_mult_koa
(
    input  logic             i_clock,
    input  gf_pkg::gf_elem_t i_data_a,
    input  gf_pkg::gf_elem_t i_data_b,
    output gf_pkg::gf_prod_t o_data
);

    localparam int NB_DATA = `GF_NB_DATA;
    localparam int NB_HALF = NB_DATA / 2;
    localparam int NB_PROD = 2*NB_DATA - 1;

    // Bit reversal between reflected and normal order.
    function automatic logic [NB_DATA-1:0] reflect(input logic [NB_DATA-1:0] v);
        logic [NB_DATA-1:0] r;
        for (int i = 0; i < NB_DATA; i++)
        begin
            r[i] = v[NB_DATA-1-i];
        end
        return r;
    endfunction

    logic [NB_DATA-1:0] data_a;
    logic [NB_DATA-1:0] data_b;
    logic [NB_HALF-1:0] data_a_high;
    logic [NB_HALF-1:0] data_a_low;
    logic [NB_HALF-1:0] data_b_high;
    logic [NB_HALF-1:0] data_b_low;
    logic [NB_DATA-2:0] dl;
    logic [NB_DATA-2:0] dh;
    logic [NB_DATA-2:0] dhl_aux1;
    logic [NB_DATA-2:0] dhl_aux2;
    logic [NB_DATA-2:0] dhl;
    logic [NB_PROD-1:0] d;

    // Normal order, x^0 in bit 0.
    assign data_a      = reflect(i_data_a);
    assign data_b      = reflect(i_data_b);
    assign data_a_high = data_a[NB_DATA-1:NB_HALF];
    assign data_a_low  = data_a[NB_HALF-1:0];
    assign data_b_high = data_b[NB_DATA-1:NB_HALF];
    assign data_b_low  = data_b[NB_HALF-1:0];

    clmul_half #(.NB_DATA(NB_HALF)) u_mult_ll
    (
        .i_data_x (data_a_low),
        .i_data_y (data_b_low),
        .o_data_z (dl)
    );

    clmul_half #(.NB_DATA(NB_HALF)) u_mult_hh
    (
        .i_data_x (data_a_high),
        .i_data_y (data_b_high),
        .o_data_z (dh)
    );

    clmul_half #(.NB_DATA(NB_HALF)) u_mult_hl
    (
        .i_data_x (data_a_high),
        .i_data_y (data_b_low),
        .o_data_z (dhl_aux1)
    );

    clmul_half #(.NB_DATA(NB_HALF)) u_mult_lh
    (
        .i_data_x (data_a_low),
        .i_data_y (data_b_high),
        .o_data_z (dhl_aux2)
    );

    // Cross terms share the middle shift.
    assign dhl = dhl_aux1 ^ dhl_aux2;

    assign d = {dh, {NB_DATA{1'b0}}}
             ^ {{NB_HALF{1'b0}}, dhl, {NB_HALF{1'b0}}}
             ^ {{NB_DATA{1'b0}}, dl};

    // Back to reflected order over the full product width.
    for (genvar ii = 0; ii < NB_PROD; ii++)
    begin : g_reflect_prod
        assign o_data[ii] = d[NB_PROD-1-ii];
    end

endmodule

// File: tb/tb_ghash_core.sv
module tb_ghash_core;

    // Budget of about 300 blocks at up to 5 cycles each.
    localparam int N_BLOCKS         = 300;
    localparam int CYCLES_PER_BLOCK = 5;
    localparam int WATCHDOG_CYCLES  = N_BLOCKS * CYCLES_PER_BLOCK + 500;
    localparam int MAX_LATENCY      = 8;
    localparam gf_pkg::gf_elem_t FIELD_ONE = 128'h8000_0000_0000_0000_0000_0000_0000_0000;
    localparam gf_pkg::gf_elem_t GCM_R     = 128'hE100_0000_0000_0000_0000_0000_0000_0000;

    logic             clk;
    logic             rst;
    logic             key_load;
    gf_pkg::gf_elem_t key;
    logic             blk_valid;
    gf_pkg::gf_elem_t blk;
    logic             clear;
    gf_pkg::gf_elem_t tag;
    logic             tag_valid;
    logic             ready;

    string            test_name;
    int               test_errors;
    int               total_errors;
    int               tests_bad;

    ghash_core u_ghash_core
    (
        .i_clock       (clk),
        .i_rst         (rst),
        .i_key_load    (key_load),
        .i_key         (key),
        .i_block_valid (blk_valid),
        .i_block       (blk),
        .i_clear       (clear),
        .o_tag         (tag),
        .o_tag_valid   (tag_valid),
        .o_ready       (ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests never finished", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // Bitwise GCM multiply with the MSB as x^0.
    // V shifts right toward higher degree.
    function automatic gf_pkg::gf_elem_t gcm_mult(input gf_pkg::gf_elem_t x,
                                                  input gf_pkg::gf_elem_t y);
        gf_pkg::gf_elem_t z;
        gf_pkg::gf_elem_t v;
        z = '0;
        v = y;
        for (int i = 127; i >= 0; i--)
        begin
            z = x[i] ? (z ^ v) : z;
            v = v[0] ? ((v >> 1) ^ GCM_R) : (v >> 1);
        end
        return z;
    endfunction

    function automatic gf_pkg::gf_elem_t rand_elem();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0)
        begin
            $display("%s: passed", test_name);
        end
        else
        begin
            $display("%s: %0d errors", test_name, test_errors);
            tests_bad++;
        end
        total_errors += test_errors;
    endtask

    task automatic check_value(input string what, input gf_pkg::gf_elem_t expected,
                               input gf_pkg::gf_elem_t actual);
        assert (actual === expected)
        else
        begin
            $display("[FAIL] %s %s expected %h actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        assert (actual == expected)
        else
        begin
            $display("[FAIL] %s %s expected %0d actual %0d", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic load_key(input gf_pkg::gf_elem_t k);
        @(posedge clk);
        key_load <= 1'b1;
        key      <= k;
        @(posedge clk);
        key_load <= 1'b0;
    endtask

    task automatic clear_acc();
        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        @(negedge clk);
        check_value("tag after clear", '0, tag);
    endtask

    // Sends one block once o_ready is high and returns the tag at its pulse.
    task automatic send_block(input gf_pkg::gf_elem_t b, output gf_pkg::gf_elem_t result);
        int lat;
        @(negedge clk);
        while (!ready)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        blk_valid <= 1'b1;
        blk       <= b;
        @(posedge clk);
        blk_valid <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (!tag_valid && lat < MAX_LATENCY)
        begin
            @(negedge clk);
            lat++;
        end
        assert (tag_valid)
        else
        begin
            $display("%s: no tag pulse came within %0d cycles of a block", test_name, lat);
            test_errors++;
        end
        if (tag_valid)
        begin
            check_count("tag latency", 2, lat);
        end
        result = tag;
    endtask

    task automatic test_single_block();
        gf_pkg::gf_elem_t h;
        gf_pkg::gf_elem_t b;
        gf_pkg::gf_elem_t t;
        begin_test("test_single_block");
        h = rand_elem();
        b = rand_elem();
        load_key(h);
        clear_acc();
        send_block(b, t);
        check_value("tag", gcm_mult(b, h), t);
        end_test();
    endtask

    task automatic test_chain();
        gf_pkg::gf_elem_t h;
        gf_pkg::gf_elem_t b;
        gf_pkg::gf_elem_t t;
        gf_pkg::gf_elem_t acc;
        begin_test("test_chain");
        h = rand_elem();
        load_key(h);
        clear_acc();
        acc = '0;
        for (int i = 0; i < 5; i++)
        begin
            b = rand_elem();
            send_block(b, t);
            acc = gcm_mult(acc ^ b, h);
            check_value("chained tag", acc, t);
        end
        end_test();
    endtask

    // With H = 1 the hash is the plain XOR of the blocks.
    task automatic test_identity_key();
        gf_pkg::gf_elem_t b;
        gf_pkg::gf_elem_t t;
        gf_pkg::gf_elem_t sum;
        begin_test("test_identity_key");
        load_key(FIELD_ONE);
        clear_acc();
        sum = '0;
        for (int i = 0; i < 4; i++)
        begin
            b   = rand_elem();
            sum = sum ^ b;
            send_block(b, t);
            check_value("xor sum", sum, t);
        end
        end_test();
    endtask

    task automatic test_clear();
        gf_pkg::gf_elem_t h;
        gf_pkg::gf_elem_t b;
        gf_pkg::gf_elem_t t;
        begin_test("test_clear");
        h = rand_elem();
        load_key(h);
        for (int i = 0; i < 3; i++)
        begin
            send_block(rand_elem(), t);
        end
        clear_acc();
        b = rand_elem();
        send_block(b, t);
        check_value("tag after clear", gcm_mult(b, h), t);
        end_test();
    endtask

    task automatic test_busy_drop();
        gf_pkg::gf_elem_t h;
        gf_pkg::gf_elem_t a;
        gf_pkg::gf_elem_t t;
        int               pulses;
        begin_test("test_busy_drop");
        h = rand_elem();
        a = rand_elem();
        t = '0;
        load_key(h);
        clear_acc();
        @(posedge clk);
        blk_valid <= 1'b1;
        blk       <= a;
        // Second strobe lands while the unit is busy.
        @(posedge clk);
        blk <= rand_elem();
        @(negedge clk);
        check_count("o_ready while busy", 0, ready);
        @(posedge clk);
        blk_valid <= 1'b0;
        pulses = 0;
        repeat (6)
        begin
            @(negedge clk);
            if (tag_valid)
            begin
                pulses++;
                t = tag;
            end
        end
        check_count("tag pulses", 1, pulses);
        check_value("tag", gcm_mult(a, h), t);
        end_test();
    endtask

    task automatic test_random();
        gf_pkg::gf_elem_t h;
        gf_pkg::gf_elem_t b;
        gf_pkg::gf_elem_t t;
        gf_pkg::gf_elem_t acc;
        begin_test("test_random");
        h = rand_elem();
        load_key(h);
        clear_acc();
        acc = '0;
        for (int i = 0; i < 200; i++)
        begin
            if ($urandom_range(7) == 0)
            begin
                h = rand_elem();
                load_key(h);
            end
            if ($urandom_range(9) == 0)
            begin
                clear_acc();
                acc = '0;
            end
            b = rand_elem();
            send_block(b, t);
            acc = gcm_mult(acc ^ b, h);
            check_value("random tag", acc, t);
        end
        end_test();
    endtask

    initial
    begin
        void'($urandom(32'h34d4));
        rst          = 1'b1;
        key_load     = 1'b0;
        key          = '0;
        blk_valid    = 1'b0;
        blk          = '0;
        clear        = 1'b0;
        total_errors = 0;
        tests_bad    = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_single_block();
        test_chain();
        test_identity_key();
        test_clear();
        test_busy_drop();
        test_random();
        $display("Summary: 6 tests, %0d with errors, %0d mismatches", tests_bad, total_errors);
        if (total_errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+source
source/gf_pkg.sv
source/clmul_half.sv
source/polinomial_mult_koa.sv
source/gf_reduce.sv
source/ghash_input.sv
source/ghash_output.sv
source/ghash_core.sv
tb/tb_ghash_core.sv
